// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int xlen          = 32;
    localparam int mem_words     = 256;                  // 1 KiB of data memory
    localparam int mem_addr_bits = $clog2(mem_words);

    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    typedef enum logic [1:0] {
        INST_NONE,
        INST_LOAD,
        INST_STORE
    } inst_type_e;

    // Encoded as funct3
    typedef enum logic [2:0] {
        LOAD_BYTE  = 3'b000,
        LOAD_HALF  = 3'b001,
        LOAD_WORD  = 3'b010,
        ULOAD_BYTE = 3'b100,
        ULOAD_HALF = 3'b101
    } mem_width_e;

    // Stores reuse the signed load codes
    localparam mem_width_e STORE_BYTE = LOAD_BYTE;
    localparam mem_width_e STORE_HALF = LOAD_HALF;
    localparam mem_width_e STORE_WORD = LOAD_WORD;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fields_t;

    // Loads decode as I-type, stores as S-type
    typedef union packed {
        i_fields_t i_type;
        s_fields_t s_type;
    } rv_instr_u;

endpackage

`default_nettype wire

// ==== mem_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

    logic                              req;        // One-cycle strobe
    logic                              we;
    logic [mem_pkg::mem_addr_bits-1:0] word_addr;
    logic [3:0]                        byte_en;
    logic [mem_pkg::xlen-1:0]          wdata;
    logic [mem_pkg::xlen-1:0]          rdata;      // Valid the cycle after a read

    modport lsu (
        output req,
        output we,
        output word_addr,
        output byte_en,
        output wdata,
        input  rdata
    );

    modport mem (
        input  req,
        input  we,
        input  word_addr,
        input  byte_en,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== ls_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module ls_decoder (
    input  logic                     iClk,
    input  logic                     reset,
    input  logic                     instr_valid,
    input  mem_pkg::rv_instr_u       instr,
    input  logic [mem_pkg::xlen-1:0] rs1_data,
    input  logic [mem_pkg::xlen-1:0] rs2_data,
    output logic                     dec_valid,
    output mem_pkg::inst_type_e      dec_type,
    output mem_pkg::mem_width_e      dec_width,
    output logic [mem_pkg::xlen-1:0] dec_addr,
    output logic [mem_pkg::xlen-1:0] dec_wdata,
    output logic [4:0]               dec_rd
);

    mem_pkg::inst_type_e      inst_type;
    logic [mem_pkg::xlen-1:0] imm_ext;
    logic [mem_pkg::xlen-1:0] eff_addr;

    always_comb begin
        if (instr.i_type.opcode == mem_pkg::opcode_load) begin
            inst_type = mem_pkg::INST_LOAD;
        end else if (instr.i_type.opcode == mem_pkg::opcode_store) begin
            inst_type = mem_pkg::INST_STORE;
        end else begin
            inst_type = mem_pkg::INST_NONE;
        end
    end

    always_comb begin
        if (inst_type == mem_pkg::INST_STORE) begin
            imm_ext = {{20{instr.s_type.imm_hi[6]}},
                       instr.s_type.imm_hi,
                       instr.s_type.imm_lo};            // Split S-type immediate
        end else begin
            imm_ext = {{20{instr.i_type.imm[11]}}, instr.i_type.imm};
        end
    end

    assign eff_addr = rs1_data + imm_ext;

    always_ff @(posedge iClk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_type  <= mem_pkg::INST_NONE;
        end else begin
            dec_valid <= instr_valid && (inst_type != mem_pkg::INST_NONE);
            dec_type  <= instr_valid ? inst_type : mem_pkg::INST_NONE;
        end
    end

    always_ff @(posedge iClk) begin
        if (instr_valid) begin
            dec_width <= mem_pkg::mem_width_e'(instr.i_type.funct3); // Same field in S-type
            dec_addr  <= eff_addr;
            dec_wdata <= rs2_data;
            dec_rd    <= instr.i_type.rd;
        end
    end

    // Non-memory opcodes never reach the load/store unit
    a_valid_has_type: assert property (
        @(posedge iClk) disable iff (reset)
        dec_valid |-> (dec_type != mem_pkg::INST_NONE)
    ) else $error("ls_decoder: dec_valid with INST_NONE");

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
    input  logic                     iClk,
    input  logic                     reset,
    input  logic                     dec_valid,
    input  mem_pkg::inst_type_e      dec_type,
    input  mem_pkg::mem_width_e      dec_width,
    input  logic [mem_pkg::xlen-1:0] dec_addr,
    input  logic [mem_pkg::xlen-1:0] dec_wdata,
    input  logic [4:0]               dec_rd,
    mem_bus_if.lsu                   bus,
    output logic                     load_valid,
    output logic [mem_pkg::xlen-1:0] load_data,
    output logic [4:0]               load_rd
);

    logic [1:0]               offset;
    logic [mem_pkg::xlen-1:0] st_data;
    logic [3:0]               st_be;
    logic                     is_load;

    logic                     ld_pending;
    logic [1:0]               ld_offset;
    mem_pkg::mem_width_e      ld_width;
    logic [4:0]               ld_rd;
    logic [7:0]               ld_byte;
    logic [15:0]              ld_half;

    assign offset  = dec_addr[1:0];
    assign is_load = dec_valid && (dec_type == mem_pkg::INST_LOAD);

    // Place store data in the addressed lanes
    always_comb begin
        case (dec_width)
            mem_pkg::STORE_BYTE: begin
                st_data = {4{dec_wdata[7:0]}};
                st_be   = 4'b0001 << offset;
            end
            mem_pkg::STORE_HALF: begin
                if (offset == 2'd3) begin
                    st_data = {dec_wdata[15:0], 16'h0000};  // Upper half
                    st_be   = 4'b1100;
                end else begin
                    st_data = {16'h0000, dec_wdata[15:0]} << {offset, 3'b000};
                    st_be   = 4'b0011 << offset;
                end
            end
            default: begin                                  // Word and unknown codes
                st_data = dec_wdata;
                st_be   = 4'b1111;
            end
        endcase
    end

    assign bus.req       = dec_valid;
    assign bus.we        = dec_valid && (dec_type == mem_pkg::INST_STORE);
    assign bus.word_addr = dec_addr[mem_pkg::mem_addr_bits+1:2]; // Wraps at memory size
    assign bus.byte_en   = bus.we ? st_be : 4'b0000;
    assign bus.wdata     = st_data;

    always_ff @(posedge iClk) begin
        if (reset) begin
            ld_pending <= 1'b0;
        end else begin
            ld_pending <= is_load;
        end
    end

    always_ff @(posedge iClk) begin
        if (is_load) begin
            ld_offset <= offset;
            ld_width  <= dec_width;
            ld_rd     <= dec_rd;
        end
    end

    assign ld_byte = bus.rdata[{ld_offset, 3'b000} +: 8];

    always_comb begin
        case (ld_offset)
            2'd0:    ld_half = bus.rdata[15:0];
            2'd1:    ld_half = bus.rdata[23:8];
            default: ld_half = bus.rdata[31:16];          // Offset 3 reads upper half
        endcase
    end

    always_comb begin
        case (ld_width)
            mem_pkg::LOAD_BYTE:  load_data = {{24{ld_byte[7]}}, ld_byte};
            mem_pkg::ULOAD_BYTE: load_data = {24'h000000, ld_byte};
            mem_pkg::LOAD_HALF:  load_data = {{16{ld_half[15]}}, ld_half};
            mem_pkg::ULOAD_HALF: load_data = {16'h0000, ld_half};
            default:             load_data = bus.rdata;
        endcase
    end

    assign load_valid = ld_pending;
    assign load_rd    = ld_rd;

    // Every store must touch at least one lane
    a_store_has_lanes: assert property (
        @(posedge iClk) disable iff (reset)
        (bus.req && bus.we) |-> (bus.byte_en != 4'b0000)
    ) else $error("load_store_unit: store with empty byte_en");

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_memory (
    input  logic   iClk,
    input  logic   reset,
    mem_bus_if.mem bus
);

    logic [mem_pkg::xlen-1:0] mem_array [mem_pkg::mem_words];

    // Byte-enabled write
    always_ff @(posedge iClk) begin
        if (bus.req && bus.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byte_en[b]) begin
                    mem_array[bus.word_addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, held until the next read
    always_ff @(posedge iClk) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= mem_array[bus.word_addr];
        end
    end

    // Lanes only light up for a write strobe
    a_be_idle: assert property (
        @(posedge iClk) disable iff (reset)
        !(bus.req && bus.we) |-> (bus.byte_en == 4'b0000)
    ) else $error("data_memory: byte_en set without write");

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top (
    input  logic                     iClk,
    input  logic                     reset,
    input  logic                     instr_valid,
    input  mem_pkg::rv_instr_u       instr,
    input  logic [mem_pkg::xlen-1:0] rs1_data,
    input  logic [mem_pkg::xlen-1:0] rs2_data,
    output logic                     load_valid,
    output logic [mem_pkg::xlen-1:0] load_data,
    output logic [4:0]               load_rd
);

    logic                     dec_valid;
    mem_pkg::inst_type_e      dec_type;
    mem_pkg::mem_width_e      dec_width;
    logic [mem_pkg::xlen-1:0] dec_addr;
    logic [mem_pkg::xlen-1:0] dec_wdata;
    logic [4:0]               dec_rd;

    mem_bus_if bus ();

    ls_decoder u_decoder (
        .iClk        (iClk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dec_valid   (dec_valid),
        .dec_type    (dec_type),
        .dec_width   (dec_width),
        .dec_addr    (dec_addr),
        .dec_wdata   (dec_wdata),
        .dec_rd      (dec_rd)
    );

    load_store_unit u_lsu (
        .iClk       (iClk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .dec_type   (dec_type),
        .dec_width  (dec_width),
        .dec_addr   (dec_addr),
        .dec_wdata  (dec_wdata),
        .dec_rd     (dec_rd),
        .bus        (bus.lsu),
        .load_valid (load_valid),
        .load_data  (load_data),
        .load_rd    (load_rd)
    );

    data_memory u_mem (
        .iClk  (iClk),
        .reset (reset),
        .bus   (bus.mem)
    );

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

    localparam int n_fill          = mem_pkg::mem_words;
    localparam int n_byte_half     = 48;
    localparam int n_word          = 16;
    localparam int n_odd           = 7;
    localparam int n_random        = 200;
    localparam int planned_strobes = n_fill + n_byte_half + n_word + n_odd + n_random;
    localparam int timeout_cycles  = 2 * planned_strobes + 50;

    typedef struct packed {
        logic [31:0] due;
        logic [31:0] data;
        logic [4:0]  rd;
    } exp_load_t;

    logic               iClk;
    logic               reset;
    logic               instr_valid;
    mem_pkg::rv_instr_u instr;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic               load_valid;
    logic [31:0]        load_data;
    logic [4:0]         load_rd;

    logic [7:0]  ref_mem [1024];             // Byte image of the data memory
    exp_load_t   exp_q [$];
    int          head = 0;                   // Next load to compare
    int          cycle = 0;
    logic        exp_valid = 1'b0;
    logic [31:0] exp_data = '0;
    logic [4:0]  exp_rd = '0;
    logic [9:0]  last_store = '0;

    mem_stage_top UUT (
        .iClk        (iClk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .load_rd     (load_rd)
    );

    initial begin
        iClk = 1'b0;
        forever #20 iClk = ~iClk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic fail_check(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
        $display("Result: FAILED");
        $fatal(1, "value mismatch");
    endtask

    function automatic logic [31:0] fill_pattern(input logic [7:0] idx);
        fill_pattern = {idx ^ 8'h5a, ~idx, idx + 8'h33, idx};
    endfunction

    // First byte of a halfword, offset 3 falls back to the upper half
    function automatic logic [9:0] half_lane(input logic [9:0] addr);
        if (addr[1:0] == 2'd3) begin
            half_lane = {addr[9:2], 2'b10};
        end else begin
            half_lane = addr;
        end
    endfunction

    function automatic logic [31:0] expect_load(input logic [9:0] addr, input logic [2:0] f3);
        logic [9:0]  base;
        logic [9:0]  hb;
        logic [7:0]  b;
        logic [15:0] h;
        base = {addr[9:2], 2'b00};
        hb   = half_lane(addr);
        b    = ref_mem[addr];
        h    = {ref_mem[hb + 10'd1], ref_mem[hb]};
        case (f3)
            3'd0:    expect_load = {{24{b[7]}}, b};
            3'd4:    expect_load = {24'd0, b};
            3'd1:    expect_load = {{16{h[15]}}, h};
            3'd5:    expect_load = {16'd0, h};
            default: expect_load = {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                                    ref_mem[base + 10'd1], ref_mem[base]};
        endcase
    endfunction

    task automatic model_store(input logic [9:0] addr, input logic [2:0] f3,
                               input logic [31:0] d);
        logic [9:0] hb;
        int         i;
        hb = half_lane(addr);
        case (f3)
            3'd0: ref_mem[addr] = d[7:0];
            3'd1: begin
                ref_mem[hb]         = d[7:0];
                ref_mem[hb + 10'd1] = d[15:8];
            end
            default: begin                            // Word and unknown widths
                for (i = 0; i < 4; i++) begin
                    ref_mem[{addr[9:2], 2'(i)}] = d[i*8 +: 8];
                end
            end
        endcase
    endtask

    task automatic issue(input logic [6:0] opcode, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [9:0] addr, input logic [31:0] wdata);
        mem_pkg::rv_instr_u word;
        exp_load_t          e;
        logic [11:0]        imm;
        logic [31:0]        base;
        imm  = 12'($urandom);
        base = {22'($urandom), addr} - {{20{imm[11]}}, imm};  // Random upper bits wrap away
        word = '0;
        if (opcode == mem_pkg::opcode_store) begin
            word.s_type.imm_hi = imm[11:5];
            word.s_type.rs2    = 5'($urandom);
            word.s_type.rs1    = 5'($urandom);
            word.s_type.funct3 = f3;
            word.s_type.imm_lo = imm[4:0];
            word.s_type.opcode = opcode;
        end else begin
            word.i_type.imm    = imm;
            word.i_type.rs1    = 5'($urandom);
            word.i_type.funct3 = f3;
            word.i_type.rd     = rd;
            word.i_type.opcode = opcode;
        end
        @(posedge iClk);
        if (opcode == mem_pkg::opcode_load) begin
            e.due  = cycle + 3;                       // Result two cycles after the strobe
            e.data = expect_load(addr, f3);
            e.rd   = rd;
            exp_q.push_back(e);
        end else if (opcode == mem_pkg::opcode_store) begin
            model_store(addr, f3, wdata);
            last_store = addr;
        end
        instr_valid <= 1'b1;
        instr       <= word;
        rs1_data    <= base;
        rs2_data    <= wdata;
    endtask

    task automatic idle();
        @(posedge iClk);
        instr_valid <= 1'b0;
        instr       <= $urandom;                      // Noise while not valid
    endtask

    always @(posedge iClk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            stop_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    // Expectation for the cycle that starts at this edge
    always @(posedge iClk) begin
        if (head < exp_q.size() && exp_q[head].due == cycle + 1) begin
            exp_valid <= 1'b1;
            exp_data  <= exp_q[head].data;
            exp_rd    <= exp_q[head].rd;
            head      <= head + 1;
        end else begin
            exp_valid <= 1'b0;
        end
    end

    a_load_valid: assert property (
        @(negedge iClk) disable iff (reset) load_valid == exp_valid
    ) else fail_check("load_valid", 32'(load_valid), 32'(exp_valid));

    a_load_data: assert property (
        @(negedge iClk) disable iff (reset) load_valid |-> (load_data == exp_data)
    ) else fail_check("load_data", load_data, exp_data);

    a_load_rd: assert property (
        @(negedge iClk) disable iff (reset) load_valid |-> (load_rd == exp_rd)
    ) else fail_check("load_rd", 32'(load_rd), 32'(exp_rd));

    a_reset_quiet: assert property (
        @(negedge iClk) reset |-> !load_valid
    ) else fail_check("load_valid", 32'(load_valid), 32'd0);

    initial begin
        int          w;
        int          pass;
        int          off;
        int          n;
        int          kind;
        logic [2:0]  f3;
        logic [9:0]  addr;
        logic [4:0]  rd;
        logic [31:0] data;
        void'($urandom(32'hd7637f28));
        reset       = 1'b1;
        instr_valid = 1'b1;                           // LW strobes held during reset
        instr       = {12'h000, 5'd0, 3'd2, 5'd1, mem_pkg::opcode_load};
        rs1_data    = '0;
        rs2_data    = '0;
        repeat (4) @(posedge iClk);
        reset       <= 1'b0;
        instr_valid <= 1'b0;

        for (w = 0; w < n_fill; w++) begin            // Every word gets a known value
            issue(mem_pkg::opcode_store, 3'd2, 5'($urandom), {w[7:0], 2'($urandom)},
                  fill_pattern(w[7:0]));
        end

        for (pass = 0; pass < 2; pass++) begin
            for (off = 0; off < 4; off++) begin
                addr     = {8'($urandom), off[1:0]};
                data     = $urandom;
                data[7]  = pass[0];                   // Both signs for byte and half
                data[15] = pass[0];
                issue(mem_pkg::opcode_store, 3'd0, 5'($urandom), addr, data);
                issue(mem_pkg::opcode_load, 3'd0, 5'($urandom), addr, $urandom);
                issue(mem_pkg::opcode_load, 3'd4, 5'($urandom), addr, $urandom);
                issue(mem_pkg::opcode_store, 3'd1, 5'($urandom), addr, data);
                issue(mem_pkg::opcode_load, 3'd1, 5'($urandom), addr, $urandom);
                issue(mem_pkg::opcode_load, 3'd5, 5'($urandom), addr, $urandom);
            end
        end

        for (n = 0; n < n_word / 2; n++) begin
            addr = 10'($urandom);
            issue(mem_pkg::opcode_store, 3'd2, 5'($urandom), addr, $urandom);
            issue(mem_pkg::opcode_load, 3'd2, 5'($urandom), {addr[9:2], 2'($urandom)}, $urandom);
        end

        issue(mem_pkg::opcode_load, 3'd3, 5'($urandom), 10'($urandom), $urandom);
        issue(mem_pkg::opcode_load, 3'd6, 5'($urandom), 10'($urandom), $urandom);
        issue(mem_pkg::opcode_load, 3'd7, 5'($urandom), 10'($urandom), $urandom);
        issue(7'b0110011, 3'd2, 5'($urandom), 10'($urandom), $urandom);
        idle();
        issue(7'b0010011, 3'd0, 5'($urandom), 10'($urandom), $urandom);
        idle();
        issue(7'b1100011, 3'd1, 5'($urandom), 10'($urandom), $urandom);
        idle();
        issue(7'b0100111, 3'd2, 5'($urandom), 10'($urandom), $urandom);  // Near the store opcode
        idle();

        for (n = 0; n < n_random; n++) begin
            kind = $urandom_range(9, 0);
            f3   = 3'($urandom);
            addr = 10'($urandom);
            rd   = 5'($urandom);
            if (kind < 4) begin
                issue(mem_pkg::opcode_store, f3, rd, addr, $urandom);
            end else if (kind < 8) begin
                issue(mem_pkg::opcode_load, f3, rd, addr, $urandom);
            end else if (kind == 8) begin
                issue(mem_pkg::opcode_load, f3, rd, {last_store[9:2], addr[1:0]}, $urandom);
            end else begin
                issue(7'b0010011, f3, rd, addr, $urandom);
            end
            if ($urandom_range(3, 0) == 0) begin
                idle();
            end
        end

        idle();
        while (head < exp_q.size()) begin
            @(posedge iClk);
        end
        repeat (3) @(posedge iClk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
mem_pkg.sv
mem_bus_if.sv
ls_decoder.sv
load_store_unit.sv
data_memory.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_mem_stage -f verilog.f \
    || { echo "Build failed"; exit 1; }
out="$(./obj_dir/Vtb_mem_stage 2>&1)"
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
